// ==== filelist.f ====
hw/axi_xbar_pkg.sv
hw/rr_arbiter.sv
hw/ar_request_port.sv
hw/ar_slave_mux.sv
hw/r_response_port.sv
hw/r_master_mux.sv
hw/axi_read_xbar.sv
bench/axi_slave_model.sv
bench/axi_read_xbar_tb.sv

// ==== bench/axi_read_xbar_tb.sv ====
/* Two random masters, each waits for its burst to finish before the next read.
   All checks sample at the rising edge and the first error stops the run. */
`timescale 1ns/1ps

module axi_read_xbar_tb;

	import axi_xbar_pkg::*;

	localparam int n_reads = 40;
	localparam int clk_period = 20;
	localparam int reset_cycles = 16;
	localparam int cycles_per_read = 200;

	logic clk;
	logic rstn;
	integer seed;

	m_ar_t m_ar [n_masters];
	logic [n_masters-1:0] m_arvalid;
	logic [n_masters-1:0] m_arready;
	m_r_t m_r [n_masters];
	logic [n_masters-1:0] m_rvalid;
	logic [n_masters-1:0] m_rready;
	s_ar_t s_ar [n_ports];
	logic [n_ports-1:0] s_arvalid;
	logic [n_ports-1:0] s_arready;
	s_r_t s_r [n_ports];
	logic [n_ports-1:0] s_rvalid;
	logic [n_ports-1:0] s_rready;

	// Scoreboard, one open read per master
	m_ar_t cur_req [n_masters];
	logic [n_masters-1:0] open;
	logic [n_masters-1:0] forwarded;
	int beat_idx [n_masters];
	int bursts_done [n_masters];
	logic [n_masters-1:0] stalled;
	m_r_t held_beat [n_masters];
	logic reset_checked;

	axi_read_xbar axi_read_xbar_inst (
		.clk(clk),
		.rstn(rstn),
		.m_ar_i(m_ar),
		.m_arvalid_i(m_arvalid),
		.m_arready_o(m_arready),
		.m_r_o(m_r),
		.m_rvalid_o(m_rvalid),
		.m_rready_i(m_rready),
		.s_ar_o(s_ar),
		.s_arvalid_o(s_arvalid),
		.s_arready_i(s_arready),
		.s_r_i(s_r),
		.s_rvalid_i(s_rvalid),
		.s_rready_o(s_rready)
	);

	for (genvar p = 0; p < n_ports; p++) begin : g_slave
		axi_slave_model #(
			.port_index(pid_t'(p)),
			.seed_init(32'h821dc192 + p)
		) slave_inst (
			.clk(clk),
			.rstn(rstn),
			.ar_i(s_ar[p]),
			.arvalid_i(s_arvalid[p]),
			.arready_o(s_arready[p]),
			.r_o(s_r[p]),
			.rvalid_o(s_rvalid[p]),
			.rready_i(s_rready[p])
		);
	end

	always #(clk_period / 2) clk = ~clk;

	// Region of an address under the fixed map
	function automatic int target_port(input addr_t addr);
		if (addr < 32'h1000_0000) begin
			return 0;
		end else if (addr < 32'h2000_0000) begin
			return 1;
		end
		return 2;
	endfunction

	function automatic m_ar_t random_read(input int region);
		m_ar_t req;
		logic [31:0] rnd;
		rnd = $random(seed);
		case (region)
			0: req.addr = {4'h0, rnd[27:2], 2'b00};
			1: req.addr = {4'h1, rnd[27:2], 2'b00};
			default: req.addr = {4'(4'h2 + rnd[31:28] % 14), rnd[27:2], 2'b00};
		endcase
		req.id = id_t'($random(seed));
		req.len = len_t'($unsigned($random(seed)) % 8);
		req.size = 3'd2;
		req.burst = 2'b01;
		return req;
	endfunction

	task automatic stop_run();
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic value_mismatch(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		$display("Fail %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
		stop_run();
	endtask

	task automatic fatal_error(input string what);
		$display("Error: %s", what);
		stop_run();
	endtask

	task automatic run_master(input int m);
		m_ar_t req;
		for (int n = 0; n < n_reads; n++) begin
			// Early reads hit the same region on both masters
			req = random_read(n < 6 ? n % 3 : $unsigned($random(seed)) % 3);
			repeat ($unsigned($random(seed)) % 3) @(posedge clk);
			m_ar[m] <= req;
			m_arvalid[m] <= 1'b1;
			@(posedge clk);
			while (!m_arready[m]) begin
				@(posedge clk);
			end
			m_arvalid[m] <= 1'b0;
			while (bursts_done[m] <= n) begin
				@(posedge clk);
			end
		end
	endtask

	always @(posedge clk) begin
		for (int m = 0; m < n_masters; m++) begin
			m_rready[m] <= rstn && ($unsigned($random(seed)) % 4 != 0);
		end
	end

	always @(posedge clk) begin : check_bus
		int mi;
		data_t exp_data;
		resp_t exp_resp;
		s_ar_t exp_ar;
		if (rstn) begin
			if (!reset_checked) begin
				assert ({s_arvalid, m_rvalid, m_arready} == 7'b0000011)
					else value_mismatch("reset_state", 64'h3,
						{s_arvalid, m_rvalid, m_arready});
				reset_checked <= 1'b1;
			end
			for (int m = 0; m < n_masters; m++) begin
				// Stalled beat must stay put
				if (stalled[m]) begin
					assert (m_rvalid[m] && m_r[m] == held_beat[m])
						else value_mismatch("beat_hold", {1'b1, held_beat[m]},
							{m_rvalid[m], m_r[m]});
				end
				stalled[m] <= m_rvalid[m] && !m_rready[m];
				held_beat[m] <= m_r[m];
				if (m_arvalid[m] && m_arready[m]) begin
					cur_req[m] <= m_ar[m];
					open[m] <= 1'b1;
					forwarded[m] <= 1'b0;
					beat_idx[m] <= 0;
				end
				if (m_rvalid[m] && m_rready[m]) begin
					assert (open[m] && forwarded[m])
						else fatal_error($sformatf("master %0d got a beat it never asked for", m));
					exp_data = cur_req[m].addr + data_t'(4 * beat_idx[m]);
					exp_resp = (target_port(cur_req[m].addr) == 2) ? resp_decerr : resp_okay;
					assert (m_r[m].data == exp_data)
						else value_mismatch("beat_data", exp_data, m_r[m].data);
					assert (m_r[m].id == cur_req[m].id)
						else value_mismatch("beat_id", cur_req[m].id, m_r[m].id);
					assert (m_r[m].last == (beat_idx[m] == int'(cur_req[m].len)))
						else value_mismatch("beat_last", beat_idx[m] == int'(cur_req[m].len),
							m_r[m].last);
					assert (m_r[m].resp == exp_resp)
						else value_mismatch("beat_resp", exp_resp, m_r[m].resp);
					beat_idx[m] <= beat_idx[m] + 1;
					if (m_r[m].last) begin
						open[m] <= 1'b0;
						bursts_done[m] <= bursts_done[m] + 1;
					end
				end
			end
			for (int p = 0; p < n_ports; p++) begin
				if (s_arvalid[p] && s_arready[p]) begin
					mi = s_ar[p].id[$bits(sid_t)-1];
					assert (target_port(s_ar[p].addr) == p)
						else value_mismatch("ar_route", p, target_port(s_ar[p].addr));
					assert (open[mi] && !forwarded[mi])
						else fatal_error($sformatf("port %0d got a read master %0d never issued",
							p, mi));
					exp_ar.addr = cur_req[mi].addr;
					exp_ar.id = {mid_t'(mi), cur_req[mi].id};
					exp_ar.len = cur_req[mi].len;
					exp_ar.size = cur_req[mi].size;
					exp_ar.burst = cur_req[mi].burst;
					assert (s_ar[p] == exp_ar)
						else value_mismatch("ar_request", exp_ar, s_ar[p]);
					forwarded[mi] <= 1'b1;
				end
			end
		end
	end

	// Bound of 200 cycles for every read of both masters
	initial begin
		#(clk_period * (reset_cycles + n_masters * n_reads * cycles_per_read));
		fatal_error("timeout, the reads did not all complete");
	end

	initial begin
		seed = 32'h821dc192;
		clk = 1'b0;
		rstn = 1'b0;
		m_arvalid = '0;
		m_rready = '0;
		open = '0;
		forwarded = '0;
		stalled = '0;
		reset_checked = 1'b0;
		for (int m = 0; m < n_masters; m++) begin
			m_ar[m] = '0;
			cur_req[m] = '0;
			held_beat[m] = '0;
			beat_idx[m] = 0;
			bursts_done[m] = 0;
		end
		repeat (reset_cycles) @(posedge clk);
		rstn <= 1'b1;
		fork
			run_master(0);
			run_master(1);
		join
		repeat (4) @(posedge clk);
		if (bursts_done[0] == n_reads && bursts_done[1] == n_reads) begin
			$display("Verification passed");
			$finish;
		end else begin
			value_mismatch("burst_count", {32'(n_reads), 32'(n_reads)},
				{32'(bursts_done[1]), 32'(bursts_done[0])});
		end
	end

endmodule

// ==== bench/axi_slave_model.sv ====
/* Serves one read at a time, with an arready delay of 0 to 3 cycles.
   Beat data is the address plus four per beat, and the default port answers DECERR. */
`timescale 1ns/1ps

module axi_slave_model #(
	parameter axi_xbar_pkg::pid_t port_index = '0,
	parameter logic [31:0] seed_init = 32'h1
) (
	input logic clk,
	input logic rstn,
	input axi_xbar_pkg::s_ar_t ar_i,
	input logic arvalid_i,
	output logic arready_o,
	output axi_xbar_pkg::s_r_t r_o,
	output logic rvalid_o,
	input logic rready_i
);

	import axi_xbar_pkg::*;

	integer seed;
	s_ar_t req;

	function automatic s_r_t make_beat(input s_ar_t ar, input int beat);
		s_r_t r;
		r.data = ar.addr + data_t'(4 * beat);
		r.id = ar.id;
		r.resp = (port_index == pid_t'(default_port)) ? resp_decerr : resp_okay;
		r.last = (beat == int'(ar.len));
		return r;
	endfunction

	initial begin
		seed = seed_init;
		arready_o = 1'b0;
		rvalid_o = 1'b0;
		r_o = '0;
		wait (rstn === 1'b1);
		@(posedge clk);
		forever begin
			repeat ($unsigned($random(seed)) % 4) @(posedge clk);
			arready_o <= 1'b1;
			@(posedge clk);
			while (!arvalid_i) begin
				@(posedge clk);
			end
			req = ar_i;
			arready_o <= 1'b0;
			// Whole burst goes out before the next request is taken
			for (int i = 0; i <= int'(req.len); i++) begin
				r_o <= make_beat(req, i);
				rvalid_o <= 1'b1;
				@(posedge clk);
				while (!rready_i) begin
					@(posedge clk);
				end
			end
			rvalid_o <= 1'b0;
		end
	end

endmodule

// ==== hw/axi_read_xbar.sv ====
/* Read-only AXI4 crossbar, two masters to three slave ports, one outstanding read per master.
   Write channels are not implemented; slave IDs are one bit wider than master IDs. */
`timescale 1ns/1ps

module axi_read_xbar (
	input logic clk,
	input logic rstn,
	input axi_xbar_pkg::m_ar_t m_ar_i [axi_xbar_pkg::n_masters],
	input logic [axi_xbar_pkg::n_masters-1:0] m_arvalid_i,
	output logic [axi_xbar_pkg::n_masters-1:0] m_arready_o,
	output axi_xbar_pkg::m_r_t m_r_o [axi_xbar_pkg::n_masters],
	output logic [axi_xbar_pkg::n_masters-1:0] m_rvalid_o,
	input logic [axi_xbar_pkg::n_masters-1:0] m_rready_i,
	output axi_xbar_pkg::s_ar_t s_ar_o [axi_xbar_pkg::n_ports],
	output logic [axi_xbar_pkg::n_ports-1:0] s_arvalid_o,
	input logic [axi_xbar_pkg::n_ports-1:0] s_arready_i,
	input axi_xbar_pkg::s_r_t s_r_i [axi_xbar_pkg::n_ports],
	input logic [axi_xbar_pkg::n_ports-1:0] s_rvalid_i,
	output logic [axi_xbar_pkg::n_ports-1:0] s_rready_o
);

	import axi_xbar_pkg::*;

	// Read address path
	pid_t req_port [n_masters];
	logic [n_masters-1:0] req_pending;
	s_ar_t req_ar [n_masters];
	logic [n_masters-1:0] ar_gnt [n_ports];

	// Read data path
	logic [n_ports-1:0] rsp_pending;
	mid_t rsp_dest [n_ports];
	logic [n_ports-1:0] rsp_rvalid;
	s_r_t rsp_r [n_ports];
	logic [n_ports-1:0] r_gnt [n_masters];

	for (genvar m = 0; m < n_masters; m++) begin : g_master
		ar_request_port #(
			.master_index(mid_t'(m))
		) u_req (
			.clk(clk),
			.rstn(rstn),
			.ar_i(m_ar_i[m]),
			.arvalid_i(m_arvalid_i[m]),
			.arready_o(m_arready_o[m]),
			.gnt_i(ar_gnt[req_port[m]][m]),
			.slave_ready_i(s_arready_i[req_port[m]]),
			.port_o(req_port[m]),
			.pending_o(req_pending[m]),
			.ar_o(req_ar[m])
		);

		r_master_mux #(
			.master_index(mid_t'(m))
		) u_rmux (
			.clk(clk),
			.rstn(rstn),
			.pending_i(rsp_pending),
			.dest_i(rsp_dest),
			.rvalid_i(rsp_rvalid),
			.r_i(rsp_r),
			.gnt_o(r_gnt[m]),
			.rvalid_o(m_rvalid_o[m]),
			.r_o(m_r_o[m])
		);
	end

	for (genvar p = 0; p < n_ports; p++) begin : g_port
		ar_slave_mux #(
			.port_index(pid_t'(p))
		) u_armux (
			.clk(clk),
			.rstn(rstn),
			.pending_i(req_pending),
			.port_i(req_port),
			.ar_i(req_ar),
			.gnt_o(ar_gnt[p]),
			.arvalid_o(s_arvalid_o[p]),
			.ar_o(s_ar_o[p])
		);

		r_response_port u_rsp (
			.clk(clk),
			.rstn(rstn),
			.rvalid_i(s_rvalid_i[p]),
			.r_i(s_r_i[p]),
			.rready_o(s_rready_o[p]),
			.gnt_i(r_gnt[rsp_dest[p]][p]),
			.master_rready_i(m_rready_i[rsp_dest[p]]),
			.pending_o(rsp_pending[p]),
			.dest_o(rsp_dest[p]),
			.rvalid_o(rsp_rvalid[p]),
			.r_o(rsp_r[p])
		);
	end

endmodule

// ==== hw/r_master_mux.sv ====
/* Picks one response port for this master and forwards its beats.
   The master index bit is dropped from the ID on the way out. */
`timescale 1ns/1ps

module r_master_mux #(
	parameter axi_xbar_pkg::mid_t master_index = '0
) (
	input logic clk,
	input logic rstn,
	input logic [axi_xbar_pkg::n_ports-1:0] pending_i,
	input axi_xbar_pkg::mid_t dest_i [axi_xbar_pkg::n_ports],
	input logic [axi_xbar_pkg::n_ports-1:0] rvalid_i,
	input axi_xbar_pkg::s_r_t r_i [axi_xbar_pkg::n_ports],
	output logic [axi_xbar_pkg::n_ports-1:0] gnt_o,
	output logic rvalid_o,
	output axi_xbar_pkg::m_r_t r_o
);

	import axi_xbar_pkg::*;

	logic [n_ports-1:0] req;
	logic gnt;
	pid_t gnt_id;
	s_r_t sel;

	always_comb begin
		for (int p = 0; p < n_ports; p++) begin
			req[p] = pending_i[p] && (dest_i[p] == master_index);
		end
	end

	rr_arbiter #(
		.n_req(n_ports)
	) u_arb (
		.clk(clk),
		.rstn(rstn),
		.req_i(req),
		.gnt_o(gnt),
		.gnt_id_o(gnt_id)
	);

	always_comb begin
		gnt_o = '0;
		if (gnt) begin
			gnt_o[gnt_id] = 1'b1;
		end
	end

	assign sel = gnt ? r_i[gnt_id] : '0;
	assign rvalid_o = gnt && rvalid_i[gnt_id];

	// Strip the master index from the ID
	assign r_o.data = sel.data;
	assign r_o.id = sel.id[$bits(id_t)-1:0];
	assign r_o.resp = sel.resp;
	assign r_o.last = sel.last;

endmodule

// ==== hw/r_response_port.sv ====
/* The first beat of a burst is registered while the destination master is arbitrated.
   Later beats pass straight through until the beat with last. */
`timescale 1ns/1ps

module r_response_port (
	input logic clk,
	input logic rstn,
	input logic rvalid_i,
	input axi_xbar_pkg::s_r_t r_i,
	output logic rready_o,
	input logic gnt_i,
	input logic master_rready_i,
	output logic pending_o,
	output axi_xbar_pkg::mid_t dest_o,
	output logic rvalid_o,
	output axi_xbar_pkg::s_r_t r_o
);

	import axi_xbar_pkg::*;

	typedef enum logic [1:0] {
		rsp_idle,
		rsp_wait_gnt,
		rsp_fwd_reg,
		rsp_pass
	} rsp_state_t;

	rsp_state_t state;
	s_r_t beat_q;
	mid_t dest_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= rsp_idle;
			dest_q <= '0;
		end else begin
			case (state)
				rsp_idle: begin
					if (rvalid_i) begin
						// Master index rides in the top ID bits
						dest_q <= r_i.id[$bits(sid_t)-1 -: $bits(mid_t)];
						state <= rsp_wait_gnt;
					end
				end
				rsp_wait_gnt: begin
					if (gnt_i) begin
						state <= rsp_fwd_reg;
					end
				end
				rsp_fwd_reg: begin
					if (master_rready_i) begin
						state <= beat_q.last ? rsp_idle : rsp_pass;
					end
				end
				rsp_pass: begin
					if (rvalid_i && master_rready_i && r_i.last) begin
						state <= rsp_idle;
					end
				end
				default: state <= rsp_idle;
			endcase
		end
	end

	// First beat of the burst
	always_ff @(posedge clk) begin
		if (state == rsp_idle && rvalid_i) begin
			beat_q <= r_i;
		end
	end

	always_comb begin
		case (state)
			rsp_idle: rready_o = 1'b1;
			rsp_pass: rready_o = master_rready_i;
			default: rready_o = 1'b0;
		endcase
	end

	assign rvalid_o = (state == rsp_fwd_reg) || (state == rsp_pass && rvalid_i);
	assign r_o = (state == rsp_pass) ? r_i : beat_q;
	assign pending_o = (state != rsp_idle);
	assign dest_o = dest_q;

	// Nothing reaches the master between the last beat and the next first beat
	a_no_beat_after_last: assert property (@(posedge clk) disable iff (!rstn)
		state == rsp_pass && rvalid_i && master_rready_i && r_i.last |=> !rvalid_o);

	// Later beats of a burst carry the same master index as the first
	a_pass_dest: assert property (@(posedge clk) disable iff (!rstn)
		state == rsp_pass && rvalid_i |-> r_i.id[$bits(sid_t)-1 -: $bits(mid_t)] == dest_q);

endmodule

// ==== hw/ar_slave_mux.sv ====
/* Arbitrates the masters that target this port and drives the winner's request.
   Outputs are zero whenever no pending master holds the grant. */
`timescale 1ns/1ps

module ar_slave_mux #(
	parameter axi_xbar_pkg::pid_t port_index = '0
) (
	input logic clk,
	input logic rstn,
	input logic [axi_xbar_pkg::n_masters-1:0] pending_i,
	input axi_xbar_pkg::pid_t port_i [axi_xbar_pkg::n_masters],
	input axi_xbar_pkg::s_ar_t ar_i [axi_xbar_pkg::n_masters],
	output logic [axi_xbar_pkg::n_masters-1:0] gnt_o,
	output logic arvalid_o,
	output axi_xbar_pkg::s_ar_t ar_o
);

	import axi_xbar_pkg::*;

	logic [n_masters-1:0] req;
	logic gnt;
	mid_t gnt_id;

	// Masters waiting on this port
	always_comb begin
		for (int m = 0; m < n_masters; m++) begin
			req[m] = pending_i[m] && (port_i[m] == port_index);
		end
	end

	rr_arbiter #(
		.n_req(n_masters)
	) u_arb (
		.clk(clk),
		.rstn(rstn),
		.req_i(req),
		.gnt_o(gnt),
		.gnt_id_o(gnt_id)
	);

	always_comb begin
		gnt_o = '0;
		if (gnt) begin
			gnt_o[gnt_id] = 1'b1;
		end
	end

	// Grant outlives the request by a cycle, so pending masks that tail
	assign arvalid_o = gnt && pending_i[gnt_id];
	assign ar_o = arvalid_o ? ar_i[gnt_id] : '0;

endmodule

// ==== hw/ar_request_port.sv ====
/* One read request per master in flight; arready stays low until the slave takes the request.
   Decode adds one cycle, so the slave sees arvalid at least 3 cycles after the master handshake. */
`timescale 1ns/1ps

module ar_request_port #(
	parameter axi_xbar_pkg::mid_t master_index = '0
) (
	input logic clk,
	input logic rstn,
	input axi_xbar_pkg::m_ar_t ar_i,
	input logic arvalid_i,
	output logic arready_o,
	input logic gnt_i,
	input logic slave_ready_i,
	output axi_xbar_pkg::pid_t port_o,
	output logic pending_o,
	output axi_xbar_pkg::s_ar_t ar_o
);

	import axi_xbar_pkg::*;

	typedef enum logic [1:0] {
		req_idle,
		req_decode,
		req_wait
	} req_state_t;

	req_state_t state;
	s_ar_t ar_q;
	pid_t port_q;

	// Mapped ranges first, everything else lands on the default port
	function automatic pid_t decode_port(addr_t addr);
		pid_t port;
		port = pid_t'(default_port);
		for (int i = 0; i < default_port; i++) begin
			if (addr >= map_base[i] && addr <= map_limit[i]) begin
				port = pid_t'(i);
			end
		end
		return port;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= req_idle;
			port_q <= port_none;
		end else begin
			case (state)
				req_idle: begin
					if (arvalid_i) begin
						state <= req_decode;
					end
				end
				req_decode: begin
					port_q <= decode_port(ar_q.addr);
					state <= req_wait;
				end
				req_wait: begin
					// Granted and accepted by the target port
					if (gnt_i && slave_ready_i) begin
						port_q <= port_none;
						state <= req_idle;
					end
				end
				default: state <= req_idle;
			endcase
		end
	end

	// Request payload with the master index prepended to the ID
	always_ff @(posedge clk) begin
		if (state == req_idle && arvalid_i) begin
			ar_q.addr <= ar_i.addr;
			ar_q.id <= {master_index, ar_i.id};
			ar_q.len <= ar_i.len;
			ar_q.size <= ar_i.size;
			ar_q.burst <= ar_i.burst;
		end
	end

	assign arready_o = (state == req_idle);
	assign pending_o = (state == req_wait);
	assign port_o = port_q;
	assign ar_o = ar_q;

endmodule

// ==== hw/rr_arbiter.sv ====
/* Grant is registered one cycle after a request and held until the granted request drops.
   A released grant costs one idle cycle before the next one is issued. */
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int n_req = 2
) (
	input logic clk,
	input logic rstn,
	input logic [n_req-1:0] req_i,
	output logic gnt_o,
	output logic [$clog2(n_req)-1:0] gnt_id_o
);

	typedef enum logic {
		arb_idle,
		arb_held
	} arb_state_t;

	arb_state_t state;
	logic [n_req-1:0] last_gnt;
	logic [n_req-1:0] above_last;
	logic [n_req-1:0] search;
	logic [n_req-1:0] pick;
	logic [$clog2(n_req)-1:0] pick_id;

	// Requesters above the previous winner go first, then wrap to the lowest one
	always_comb begin
		above_last = '0;
		for (int i = 1; i < n_req; i++) begin
			above_last[i] = above_last[i-1] | last_gnt[i-1];
		end
		search = (|(req_i & above_last)) ? (req_i & above_last) : req_i;
		pick = '0;
		pick_id = '0;
		// Walk downwards so the lowest set bit is the one left standing
		for (int i = n_req - 1; i >= 0; i--) begin
			if (search[i]) begin
				pick = '0;
				pick[i] = 1'b1;
				pick_id = i[$clog2(n_req)-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= arb_idle;
			last_gnt <= '0;
			gnt_id_o <= '0;
		end else begin
			case (state)
				arb_idle: begin
					if (|pick) begin
						state <= arb_held;
						last_gnt <= pick;
						gnt_id_o <= pick_id;
					end
				end
				arb_held: begin
					if (!req_i[gnt_id_o]) begin
						state <= arb_idle;
					end
				end
				default: state <= arb_idle;
			endcase
		end
	end

	assign gnt_o = (state == arb_held);

	a_gnt_onehot: assert property (@(posedge clk) disable iff (!rstn)
		state == arb_held |-> $onehot(last_gnt) && last_gnt[gnt_id_o]);

endmodule

// ==== hw/axi_xbar_pkg.sv ====
/* Two masters, three slave ports; port 2 is the default port and gets every unmapped address.
   Addresses are forwarded unchanged, and the slave-side ID carries the master index on top. */
package axi_xbar_pkg;

	localparam int n_masters = 2;
	localparam int n_ports = 3;
	localparam int default_port = 2;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] id_t;
	typedef logic [0:0] mid_t;
	typedef logic [1:0] pid_t;
	// Master index sits above the master's own ID
	typedef logic [$bits(mid_t)+$bits(id_t)-1:0] sid_t;
	typedef logic [7:0] len_t;
	typedef logic [1:0] resp_t;

	localparam resp_t resp_okay = 2'd0;
	localparam resp_t resp_decerr = 2'd3;

	// Selected-port value of an idle request port
	localparam pid_t port_none = 2'd3;

	// One entry per mapped port, limits inclusive
	localparam addr_t map_base [default_port] = '{32'h0000_0000, 32'h1000_0000};
	localparam addr_t map_limit [default_port] = '{32'h0FFF_FFFF, 32'h1FFF_FFFF};

	typedef struct packed {
		addr_t addr;
		id_t id;
		len_t len;
		logic [2:0] size;
		logic [1:0] burst;
	} m_ar_t;

	typedef struct packed {
		addr_t addr;
		sid_t id;
		len_t len;
		logic [2:0] size;
		logic [1:0] burst;
	} s_ar_t;

	typedef struct packed {
		data_t data;
		sid_t id;
		resp_t resp;
		logic last;
	} s_r_t;

	typedef struct packed {
		data_t data;
		id_t id;
		resp_t resp;
		logic last;
	} m_r_t;

endpackage
